// ==== flist.f ====
+incdir+dv
common/dm_mem_pkg.sv
common/dm_hart_evt_if.sv
hart_ctrl/dm_hart_ctrl.sv
bus_window/dm_bus_window.sv
hdl/dm_mem_top.sv
dv/tb_dm_mem.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_dm_mem
FLIST     := flist.f
FLAGS     := --timing -Wno-fatal
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_dm_model.svh ====
`ifndef TB_DM_MODEL_SVH
`define TB_DM_MODEL_SVH

// reference state, advanced once per rising edge
dm_mem_pkg::hart_vec_t   m_halted;
dm_mem_pkg::hart_vec_t   m_resuming;
dm_mem_pkg::ctrl_state_e m_state;
dm_mem_pkg::bus_data_t   m_rdata;

task automatic model_reset();
    m_halted   = '0;
    m_resuming = '0;
    m_state    = dm_mem_pkg::Idle;
    m_rdata    = '0;
endtask

function automatic logic wrote_to(dm_mem_pkg::dbg_addr_t a);
    return req_i && we_i && (addr_i == a);
endfunction

function automatic logic data_write();
    return req_i && we_i && (addr_i >= dm_mem_pkg::DataAddr) && (addr_i <= dm_mem_pkg::DataEnd);
endfunction

// {valid, code}, exception report beats the halt/resume error
function automatic logic [3:0] expected_error();
    if (wrote_to(dm_mem_pkg::ExceptionAddr)) begin
        return {1'b1, dm_mem_pkg::CmdErrException};
    end
    if (m_state == dm_mem_pkg::Idle && cmd_valid_i && !m_halted[hartsel_i]) begin
        return {1'b1, dm_mem_pkg::CmdErrHaltResume};
    end
    return {1'b0, dm_mem_pkg::CmdErrNone};
endfunction

function automatic logic [63:0] expected_data_o();
    dm_mem_pkg::bus_data_t [dm_mem_pkg::DataCount-1:0] d;
    dm_mem_pkg::bus_data_t                             mask;
    dm_mem_pkg::dbg_addr_t                             off;
    d    = data_i;
    mask = {{8{be_i[3]}}, {8{be_i[2]}}, {8{be_i[1]}}, {8{be_i[0]}}};
    off  = addr_i - dm_mem_pkg::DataAddr;
    if (data_write()) begin
        d[off[dm_mem_pkg::DataIdxBits+1:2]] =
            (d[off[dm_mem_pkg::DataIdxBits+1:2]] & ~mask) | (wdata_i & mask);
    end
    return d;
endfunction

function automatic dm_mem_pkg::bus_data_t predicted_rdata();
    dm_mem_pkg::bus_data_t r;
    dm_mem_pkg::dbg_addr_t off;
    r = m_rdata;
    if (!req_i || we_i) begin
        return r;
    end
    if (addr_i == dm_mem_pkg::WhereToAddr) begin
        if (m_state != dm_mem_pkg::Idle) begin
            r = dm_mem_pkg::JumpProgBuf;
        end else if (resumereq_i[wdata_i[dm_mem_pkg::HartSelBits-1:0]]) begin
            r = dm_mem_pkg::JumpResume;
        end
    end else if (addr_i >= dm_mem_pkg::DataAddr && addr_i <= dm_mem_pkg::DataEnd) begin
        off = addr_i - dm_mem_pkg::DataAddr;
        r   = data_i[off[dm_mem_pkg::DataIdxBits+1:2]];
    end else if (addr_i >= dm_mem_pkg::ProgBufBase && addr_i <= dm_mem_pkg::ProgBufEnd) begin
        off = addr_i - dm_mem_pkg::ProgBufBase;
        r   = progbuf_i[off[dm_mem_pkg::ProgBufIdxBits+1:2]];
    end else if (addr_i >= dm_mem_pkg::FlagsBase && addr_i <= dm_mem_pkg::FlagsEnd) begin
        off = addr_i - dm_mem_pkg::FlagsBase;
        r   = '0;
        // one byte per hart holding {resume, go}
        if (int'(off >> 2) == int'(hartsel_i) / 4) begin
            r = dm_mem_pkg::bus_data_t'({6'b0, m_state == dm_mem_pkg::Resume,
                                         m_state == dm_mem_pkg::Go}) << (8 * (int'(hartsel_i) % 4));
        end
    end
    return r;
endfunction

task automatic model_update();
    dm_mem_pkg::hart_sel_t   h;
    dm_mem_pkg::ctrl_state_e nxt;
    h   = wdata_i[dm_mem_pkg::HartSelBits-1:0];
    nxt = m_state;
    case (m_state)
        dm_mem_pkg::Idle: begin
            if (cmd_valid_i && m_halted[hartsel_i]) begin
                nxt = dm_mem_pkg::Go;
            end
            if (resumereq_i[hartsel_i] && m_halted[hartsel_i] && !m_resuming[hartsel_i] &&
                !haltreq_i[hartsel_i]) begin
                nxt = dm_mem_pkg::Resume;
            end
        end
        dm_mem_pkg::Go: begin
            if (wrote_to(dm_mem_pkg::GoingAddr)) begin
                nxt = dm_mem_pkg::CmdExecuting;
            end
        end
        dm_mem_pkg::Resume: begin
            if (m_resuming[hartsel_i]) begin
                nxt = dm_mem_pkg::Idle;
            end
        end
        default: begin
            if (wrote_to(dm_mem_pkg::HaltedAddr) && h == hartsel_i) begin
                nxt = dm_mem_pkg::Idle;
            end
        end
    endcase
    m_rdata = predicted_rdata();
    m_state = nxt;
    if (clear_resumeack_i) begin
        m_resuming[hartsel_i] = 1'b0;
    end
    if (wrote_to(dm_mem_pkg::HaltedAddr)) begin
        m_halted[h] = 1'b1;
    end
    if (wrote_to(dm_mem_pkg::ResumingAddr)) begin
        m_halted[h]   = 1'b0;
        m_resuming[h] = 1'b1;
    end
endtask

`endif

// ==== dv/tb_dm_mem.sv ====
`timescale 1ns/1ns

module tb_dm_mem;

    localparam int unsigned Seed        = 32'h21f4263b;
    localparam int unsigned ResetCycles = 10;
    localparam int unsigned Timeout     = 40;

    logic                                                clk_i;
    logic                                                rst_ni;
    dm_mem_pkg::hart_vec_t                               haltreq_i, resumereq_i;
    dm_mem_pkg::hart_sel_t                               hartsel_i;
    logic                                                clear_resumeack_i, cmd_valid_i;
    dm_mem_pkg::hart_vec_t                               debug_req_o, halted_o, resuming_o;
    logic                                                cmdbusy_o, cmderror_valid_o;
    dm_mem_pkg::cmderr_e                                 cmderror_o;
    dm_mem_pkg::bus_data_t [dm_mem_pkg::ProgBufSize-1:0] progbuf_i;
    dm_mem_pkg::bus_data_t [dm_mem_pkg::DataCount-1:0]   data_i, data_o;
    logic                                                data_valid_o;
    logic                                                req_i, we_i;
    dm_mem_pkg::dbg_addr_t                               addr_i;
    dm_mem_pkg::bus_data_t                               wdata_i, rdata_o;
    dm_mem_pkg::bus_strb_t                               be_i;

    int    errors;
    int    checks;
    int    timeouts;
    string test_name;

    `include "tb_dm_model.svh"

    dm_mem_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // --------------------
    // checking
    // --------------------
    task automatic compare(string what, logic [63:0] exp, logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_comb();
        logic [3:0] err;
        err = expected_error();
        compare("cmderror_valid_o", err[3], cmderror_valid_o);
        compare("cmderror_o", err[2:0], cmderror_o);
        compare("data_valid_o", data_write(), data_valid_o);
        compare("data_o", expected_data_o(), data_o);
        // halt requests pass straight through
        compare("debug_req_o", haltreq_i, debug_req_o);
    endtask

    task automatic check_regs();
        compare("halted_o", m_halted, halted_o);
        compare("resuming_o", m_resuming, resuming_o);
        compare("cmdbusy_o", m_state != dm_mem_pkg::Idle, cmdbusy_o);
        compare("rdata_o", m_rdata, rdata_o);
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    // --------------------
    // stimulus
    // --------------------
    // called on a falling edge with the inputs already driven
    task automatic step();
        #1;
        check_comb();
        @(posedge clk_i);
        model_update();
        @(negedge clk_i);
        check_regs();
    endtask

    task automatic release_strobes();
        req_i             = 1'b0;
        we_i              = 1'b0;
        cmd_valid_i       = 1'b0;
        clear_resumeack_i = 1'b0;
    endtask

    task automatic idle_cycle();
        release_strobes();
        step();
    endtask

    task automatic bus_access(logic we, dm_mem_pkg::dbg_addr_t addr,
                              dm_mem_pkg::bus_data_t wdata, dm_mem_pkg::bus_strb_t be);
        release_strobes();
        req_i   = 1'b1;
        we_i    = we;
        addr_i  = addr;
        wdata_i = wdata;
        be_i    = be;
        step();
    endtask

    task automatic issue_command();
        release_strobes();
        cmd_valid_i = 1'b1;
        step();
    endtask

    task automatic randomize_buffers();
        for (int i = 0; i < dm_mem_pkg::ProgBufSize; i++) begin
            progbuf_i[i] = $urandom();
        end
        for (int i = 0; i < dm_mem_pkg::DataCount; i++) begin
            data_i[i] = $urandom();
        end
    endtask

    task automatic wait_cmdbusy(logic level);
        int n;
        n = 0;
        while (cmdbusy_o !== level && n < Timeout) begin
            idle_cycle();
            n++;
        end
        if (cmdbusy_o !== level) begin
            $display("timeout in %s: cmdbusy_o never went to %0b", test_name, level);
            timeouts++;
        end
    endtask

    task automatic wait_resuming(dm_mem_pkg::hart_sel_t hart);
        int n;
        n = 0;
        while (resuming_o[hart] !== 1'b1 && n < Timeout) begin
            idle_cycle();
            n++;
        end
        if (resuming_o[hart] !== 1'b1) begin
            $display("timeout in %s: hart %0d never reported resuming", test_name, hart);
            timeouts++;
        end
    endtask

    // hart 0 is always halted by the first phase
    function automatic dm_mem_pkg::hart_sel_t pick_halted_hart();
        dm_mem_pkg::hart_sel_t h;
        h = dm_mem_pkg::hart_sel_t'($urandom());
        for (int i = 0; i < dm_mem_pkg::NrHarts && !m_halted[h]; i++) begin
            h = h + 1'b1;
        end
        return h;
    endfunction

    // --------------------
    // test sequence
    // --------------------
    initial begin
        dm_mem_pkg::hart_sel_t h;
        dm_mem_pkg::dbg_addr_t rd_addr;
        int unsigned           sel;

        void'($urandom(Seed));
        errors      = 0;
        checks      = 0;
        timeouts    = 0;
        test_name   = "reset";
        rst_ni      = 1'b0;
        haltreq_i   = '0;
        resumereq_i = '0;
        hartsel_i   = '0;
        addr_i      = '0;
        wdata_i     = '0;
        be_i        = '0;
        release_strobes();
        randomize_buffers();
        model_reset();
        repeat (ResetCycles) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_regs();
        idle_cycle();

        // hart 3 is kept running for the error case
        test_name = "halted_writes";
        bus_access(1'b1, dm_mem_pkg::HaltedAddr, '0, '1);
        repeat (6) begin
            bus_access(1'b1, dm_mem_pkg::HaltedAddr,
                       dm_mem_pkg::bus_data_t'($urandom_range(2, 0)), '1);
        end

        test_name = "data_access";
        repeat (24) begin
            randomize_buffers();
            sel = $urandom_range(1, 0);
            bus_access(1'b1, dm_mem_pkg::DataAddr + dm_mem_pkg::dbg_addr_t'(4 * sel), $urandom(),
                       dm_mem_pkg::bus_strb_t'($urandom()));
            case ($urandom_range(2, 0))
                0: rd_addr = dm_mem_pkg::DataAddr +
                             dm_mem_pkg::dbg_addr_t'(4 * $urandom_range(1, 0));
                1: rd_addr = dm_mem_pkg::ProgBufBase +
                             dm_mem_pkg::dbg_addr_t'(4 * $urandom_range(7, 0));
                default: rd_addr = 12'h000;
            endcase
            bus_access(1'b0, rd_addr, $urandom(), '0);
        end

        test_name = "cmd_unhalted";
        hartsel_i = 2'd3;
        issue_command();

        test_name = "cmd_halted";
        h         = pick_halted_hart();
        hartsel_i = h;
        issue_command();
        wait_cmdbusy(1'b1);
        bus_access(1'b0, dm_mem_pkg::FlagsBase + dm_mem_pkg::dbg_addr_t'(4 * $urandom_range(3, 0)),
                   $urandom(), '0);
        bus_access(1'b0, dm_mem_pkg::FlagsBase, $urandom(), '0);
        bus_access(1'b0, dm_mem_pkg::WhereToAddr, dm_mem_pkg::bus_data_t'(h), '0);
        compare("whereto_progbuf", dm_mem_pkg::JumpProgBuf, rdata_o);
        bus_access(1'b1, dm_mem_pkg::GoingAddr, dm_mem_pkg::bus_data_t'(h), '1);

        test_name = "exception";
        bus_access(1'b1, dm_mem_pkg::ExceptionAddr, dm_mem_pkg::bus_data_t'(h), '1);
        test_name = "cmd_done";
        bus_access(1'b1, dm_mem_pkg::HaltedAddr, dm_mem_pkg::bus_data_t'(h), '1);
        wait_cmdbusy(1'b0);

        test_name   = "resume";
        h           = pick_halted_hart();
        hartsel_i   = h;
        resumereq_i = dm_mem_pkg::hart_vec_t'(1) << h;
        idle_cycle();
        bus_access(1'b0, dm_mem_pkg::FlagsBase, $urandom(), '0);
        bus_access(1'b1, dm_mem_pkg::ResumingAddr, dm_mem_pkg::bus_data_t'(h), '1);
        wait_resuming(h);
        wait_cmdbusy(1'b0);
        bus_access(1'b0, dm_mem_pkg::WhereToAddr, dm_mem_pkg::bus_data_t'(h), '0);
        compare("whereto_resume", dm_mem_pkg::JumpResume, rdata_o);
        release_strobes();
        clear_resumeack_i = 1'b1;
        step();
        resumereq_i = '0;
        idle_cycle();

        test_name = "debug_req";
        repeat (16) begin
            haltreq_i = dm_mem_pkg::hart_vec_t'($urandom());
            idle_cycle();
        end

        finish_run();
    end

endmodule

// ==== hdl/dm_mem_top.sv ====
`timescale 1ns/1ns

module dm_mem_top (
    input  logic                                               clk_i,
    input  logic                                               rst_ni,

    // debugger side
    input  dm_mem_pkg::hart_vec_t                              haltreq_i,
    input  dm_mem_pkg::hart_vec_t                              resumereq_i,
    input  dm_mem_pkg::hart_sel_t                              hartsel_i,
    input  logic                                               clear_resumeack_i,
    input  logic                                               cmd_valid_i,

    output dm_mem_pkg::hart_vec_t                              debug_req_o,
    output dm_mem_pkg::hart_vec_t                              halted_o,
    output dm_mem_pkg::hart_vec_t                              resuming_o,
    output logic                                               cmdbusy_o,
    output logic                                               cmderror_valid_o,
    output dm_mem_pkg::cmderr_e                                cmderror_o,

    input  dm_mem_pkg::bus_data_t [dm_mem_pkg::ProgBufSize-1:0] progbuf_i,
    input  dm_mem_pkg::bus_data_t [dm_mem_pkg::DataCount-1:0]   data_i,
    output dm_mem_pkg::bus_data_t [dm_mem_pkg::DataCount-1:0]   data_o,
    output logic                                               data_valid_o,

    // hart side SRAM bus
    input  logic                                               req_i,
    input  logic                                               we_i,
    input  dm_mem_pkg::dbg_addr_t                              addr_i,
    input  dm_mem_pkg::bus_data_t                              wdata_i,
    input  dm_mem_pkg::bus_strb_t                              be_i,
    output dm_mem_pkg::bus_data_t                              rdata_o
);

    dm_hart_evt_if evt_if ();

    // halt requests go straight to the harts
    assign debug_req_o = haltreq_i;

    dm_hart_ctrl u_hart_ctrl (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .haltreq_i         (haltreq_i),
        .resumereq_i       (resumereq_i),
        .hartsel_i         (hartsel_i),
        .clear_resumeack_i (clear_resumeack_i),
        .cmd_valid_i       (cmd_valid_i),
        .halted_o          (halted_o),
        .resuming_o        (resuming_o),
        .cmdbusy_o         (cmdbusy_o),
        .cmderror_valid_o  (cmderror_valid_o),
        .cmderror_o        (cmderror_o),
        .evt_if            (evt_if.ctrl)
    );

    dm_bus_window u_bus_window (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (req_i),
        .we_i         (we_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .be_i         (be_i),
        .rdata_o      (rdata_o),
        .progbuf_i    (progbuf_i),
        .data_i       (data_i),
        .data_o       (data_o),
        .data_valid_o (data_valid_o),
        .hartsel_i    (hartsel_i),
        .evt_if       (evt_if.win)
    );

endmodule

// ==== bus_window/dm_bus_window.sv ====
`timescale 1ns/1ns

module dm_bus_window (
    input  logic                                               clk_i,
    input  logic                                               rst_ni,

    // hart side bus
    input  logic                                               req_i,
    input  logic                                               we_i,
    input  dm_mem_pkg::dbg_addr_t                              addr_i,
    input  dm_mem_pkg::bus_data_t                              wdata_i,
    input  dm_mem_pkg::bus_strb_t                              be_i,
    output dm_mem_pkg::bus_data_t                              rdata_o,

    input  dm_mem_pkg::bus_data_t [dm_mem_pkg::ProgBufSize-1:0] progbuf_i,
    input  dm_mem_pkg::bus_data_t [dm_mem_pkg::DataCount-1:0]   data_i,
    output dm_mem_pkg::bus_data_t [dm_mem_pkg::DataCount-1:0]   data_o,
    output logic                                               data_valid_o,
    input  dm_mem_pkg::hart_sel_t                              hartsel_i,

    dm_hart_evt_if.win                                         evt_if
);

    logic                  is_read, is_write;
    logic                  in_data, in_pbuf, in_flags;
    dm_mem_pkg::dbg_addr_t data_off, pbuf_off, flags_off;
    dm_mem_pkg::dbg_addr_t hart_byte;
    dm_mem_pkg::bus_data_t flags_word;
    dm_mem_pkg::bus_data_t rdata_d, rdata_q;

    logic [dm_mem_pkg::DataIdxBits-1:0]    data_idx;
    logic [dm_mem_pkg::ProgBufIdxBits-1:0] pbuf_idx;

    assign is_read  = req_i && !we_i;
    assign is_write = req_i && we_i;

    // --------------------
    // address decode
    // --------------------
    assign in_data  = (addr_i >= dm_mem_pkg::DataAddr) && (addr_i <= dm_mem_pkg::DataEnd);
    assign in_pbuf  = (addr_i >= dm_mem_pkg::ProgBufBase) && (addr_i <= dm_mem_pkg::ProgBufEnd);
    assign in_flags = (addr_i >= dm_mem_pkg::FlagsBase) && (addr_i <= dm_mem_pkg::FlagsEnd);

    assign data_off  = addr_i - dm_mem_pkg::DataAddr;
    assign pbuf_off  = addr_i - dm_mem_pkg::ProgBufBase;
    assign flags_off = addr_i - dm_mem_pkg::FlagsBase;

    // word index inside each region
    assign data_idx = data_off[dm_mem_pkg::DataIdxBits+1:2];
    assign pbuf_idx = pbuf_off[dm_mem_pkg::ProgBufIdxBits+1:2];

    // --------------------
    // hart write events
    // --------------------
    assign evt_if.halted_we    = is_write && (addr_i == dm_mem_pkg::HaltedAddr);
    assign evt_if.going_we     = is_write && (addr_i == dm_mem_pkg::GoingAddr);
    assign evt_if.resuming_we  = is_write && (addr_i == dm_mem_pkg::ResumingAddr);
    assign evt_if.exception_we = is_write && (addr_i == dm_mem_pkg::ExceptionAddr);
    // the hart writes its own index
    assign evt_if.evt_hart     = wdata_i[dm_mem_pkg::HartSelBits-1:0];

    // data register merge, only visible while the write lasts
    always_comb begin
        data_o = data_i;
        if (is_write && in_data) begin
            for (int unsigned b = 0; b < dm_mem_pkg::BusStrbBits; b++) begin
                if (be_i[b]) begin
                    data_o[data_idx][b*8 +: 8] = wdata_i[b*8 +: 8];
                end
            end
        end
    end

    assign data_valid_o = is_write && in_data;

    // --------------------
    // flags area
    // --------------------
    // one byte per hart, four harts per word
    assign hart_byte = dm_mem_pkg::dbg_addr_t'(hartsel_i);

    always_comb begin
        flags_word = '0;
        if (flags_off[dm_mem_pkg::DbgAddrBits-1:2] == hart_byte[dm_mem_pkg::DbgAddrBits-1:2]) begin
            flags_word[{hart_byte[1:0], 3'b000} +: 8] = {6'b0, evt_if.resume, evt_if.go};
        end
    end

    // --------------------
    // read mux
    // --------------------
    always_comb begin
        // unmapped reads keep the last word
        rdata_d = rdata_q;
        if (is_read) begin
            if (addr_i == dm_mem_pkg::WhereToAddr) begin
                if (evt_if.cmdbusy) begin
                    rdata_d = dm_mem_pkg::JumpProgBuf;
                end else if (evt_if.resumereq_sel) begin
                    rdata_d = dm_mem_pkg::JumpResume;
                end
            end else if (in_data) begin
                rdata_d = data_i[data_idx];
            end else if (in_pbuf) begin
                rdata_d = progbuf_i[pbuf_idx];
            end else if (in_flags) begin
                rdata_d = flags_word;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q <= '0;
        end else begin
            rdata_q <= rdata_d;
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== hart_ctrl/dm_hart_ctrl.sv ====
`timescale 1ns/1ns

module dm_hart_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    input  dm_mem_pkg::hart_vec_t   haltreq_i,
    input  dm_mem_pkg::hart_vec_t   resumereq_i,
    input  dm_mem_pkg::hart_sel_t   hartsel_i,
    input  logic                    clear_resumeack_i,
    input  logic                    cmd_valid_i,

    output dm_mem_pkg::hart_vec_t   halted_o,
    output dm_mem_pkg::hart_vec_t   resuming_o,
    output logic                    cmdbusy_o,
    output logic                    cmderror_valid_o,
    output dm_mem_pkg::cmderr_e     cmderror_o,

    dm_hart_evt_if.ctrl             evt_if
);

    dm_mem_pkg::hart_vec_t   halted_d, halted_q;
    dm_mem_pkg::hart_vec_t   resuming_d, resuming_q;
    dm_mem_pkg::ctrl_state_e state_d, state_q;
    logic                    sel_halted_evt;

    assign halted_o   = halted_q;
    assign resuming_o = resuming_q;

    // halted write coming from the hart we are driving
    assign sel_halted_evt = evt_if.halted_we && (evt_if.evt_hart == hartsel_i);

    // --------------------
    // per-hart flags
    // --------------------
    always_comb begin
        halted_d   = halted_q;
        resuming_d = resuming_q;

        // debugger acknowledged the resume
        if (clear_resumeack_i) begin
            resuming_d[hartsel_i] = 1'b0;
        end

        if (evt_if.halted_we) begin
            halted_d[evt_if.evt_hart] = 1'b1;
        end

        // hart left debug mode, keep resuming until acked
        if (evt_if.resuming_we) begin
            halted_d[evt_if.evt_hart]   = 1'b0;
            resuming_d[evt_if.evt_hart] = 1'b1;
        end
    end

    // --------------------
    // command FSM
    // --------------------
    always_comb begin
        state_d          = state_q;
        cmderror_valid_o = 1'b0;
        cmderror_o       = dm_mem_pkg::CmdErrNone;

        case (state_q)
            dm_mem_pkg::Idle: begin
                if (cmd_valid_i && halted_q[hartsel_i]) begin
                    state_d = dm_mem_pkg::Go;
                end else if (cmd_valid_i) begin
                    // commands need a halted hart
                    cmderror_valid_o = 1'b1;
                    cmderror_o       = dm_mem_pkg::CmdErrHaltResume;
                end
                // ignored while a halt is requested or the last resume is unacked
                if (resumereq_i[hartsel_i] && !resuming_q[hartsel_i] &&
                    !haltreq_i[hartsel_i] && halted_q[hartsel_i]) begin
                    state_d = dm_mem_pkg::Resume;
                end
            end

            dm_mem_pkg::Go: begin
                // hart picked up the go flag
                if (evt_if.going_we) begin
                    state_d = dm_mem_pkg::CmdExecuting;
                end
            end

            dm_mem_pkg::Resume: begin
                if (resuming_q[hartsel_i]) begin
                    state_d = dm_mem_pkg::Idle;
                end
            end

            dm_mem_pkg::CmdExecuting: begin
                // program buffer ends in ebreak, the hart halts again
                if (sel_halted_evt) begin
                    state_d = dm_mem_pkg::Idle;
                end
            end

            default: begin
                state_d = dm_mem_pkg::Idle;
            end
        endcase

        // exception report wins over the halt/resume error
        if (evt_if.exception_we) begin
            cmderror_valid_o = 1'b1;
            cmderror_o       = dm_mem_pkg::CmdErrException;
        end
    end

    assign cmdbusy_o = (state_q != dm_mem_pkg::Idle);

    assign evt_if.go            = (state_q == dm_mem_pkg::Go);
    assign evt_if.resume        = (state_q == dm_mem_pkg::Resume);
    assign evt_if.cmdbusy       = cmdbusy_o;
    assign evt_if.resumereq_sel = resumereq_i[evt_if.evt_hart];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= dm_mem_pkg::Idle;
            halted_q   <= '0;
            resuming_q <= '0;
        end else begin
            state_q    <= state_d;
            halted_q   <= halted_d;
            resuming_q <= resuming_d;
        end
    end

endmodule

// ==== common/dm_hart_evt_if.sv ====
`timescale 1ns/1ns

interface dm_hart_evt_if;

    // hart write strobes, one cycle each
    logic                  halted_we;
    logic                  going_we;
    logic                  resuming_we;
    logic                  exception_we;
    // index the hart wrote as data
    dm_mem_pkg::hart_sel_t evt_hart;

    // levels from the controller
    logic                  go;
    logic                  resume;
    logic                  cmdbusy;
    logic                  resumereq_sel;

    modport win (
        output halted_we,
        output going_we,
        output resuming_we,
        output exception_we,
        output evt_hart,
        input  go,
        input  resume,
        input  cmdbusy,
        input  resumereq_sel
    );

    modport ctrl (
        input  halted_we,
        input  going_we,
        input  resuming_we,
        input  exception_we,
        input  evt_hart,
        output go,
        output resume,
        output cmdbusy,
        output resumereq_sel
    );

endinterface

// ==== common/dm_mem_pkg.sv ====
package dm_mem_pkg;

    // --------------------
    // sizes
    // --------------------
    localparam int unsigned NrHarts     = 4;
    localparam int unsigned ProgBufSize = 8;
    localparam int unsigned DataCount   = 2;
    localparam int unsigned BusWidth    = 32;
    localparam int unsigned DbgAddrBits = 12;

    localparam int unsigned BusStrbBits    = BusWidth / 8;
    localparam int unsigned HartSelBits    = $clog2(NrHarts);
    localparam int unsigned DataIdxBits    = $clog2(DataCount);
    localparam int unsigned ProgBufIdxBits = $clog2(ProgBufSize);

    typedef logic [DbgAddrBits-1:0] dbg_addr_t;
    typedef logic [BusWidth-1:0]    bus_data_t;
    typedef logic [BusStrbBits-1:0] bus_strb_t;
    typedef logic [NrHarts-1:0]     hart_vec_t;
    typedef logic [HartSelBits-1:0] hart_sel_t;

    // --------------------
    // address map
    // --------------------
    // hart write-only locations
    localparam dbg_addr_t HaltedAddr    = 12'h100;
    localparam dbg_addr_t GoingAddr     = 12'h104;
    localparam dbg_addr_t ResumingAddr  = 12'h108;
    localparam dbg_addr_t ExceptionAddr = 12'h10C;

    localparam dbg_addr_t WhereToAddr = 12'h300;
    localparam dbg_addr_t DataAddr    = 12'h380;
    localparam dbg_addr_t DataEnd     = DataAddr + dbg_addr_t'(4 * DataCount - 1);
    // program buffer sits directly below the data registers
    localparam dbg_addr_t ProgBufBase = DataAddr - dbg_addr_t'(4 * ProgBufSize);
    localparam dbg_addr_t ProgBufEnd  = DataAddr - 12'd1;
    localparam dbg_addr_t FlagsBase   = 12'h400;
    localparam dbg_addr_t FlagsEnd    = 12'h7FF;
    localparam dbg_addr_t ResumeAddr  = 12'h804;

    // --------------------
    // jump words at WhereTo
    // --------------------
    localparam logic [6:0]  JalOpcode   = 7'h6F;
    localparam logic [20:0] ProgBufOff  = 21'(ProgBufBase - WhereToAddr);
    localparam logic [20:0] ResumeOff   = 21'(ResumeAddr - WhereToAddr);

    // jal x0, imm with the J-type immediate scramble
    localparam bus_data_t JumpProgBuf = {ProgBufOff[20], ProgBufOff[10:1], ProgBufOff[11],
                                         ProgBufOff[19:12], 5'd0, JalOpcode};
    localparam bus_data_t JumpResume  = {ResumeOff[20], ResumeOff[10:1], ResumeOff[11],
                                         ResumeOff[19:12], 5'd0, JalOpcode};

    // cmderr codes as in abstractcs
    typedef enum logic [2:0] {
        CmdErrNone       = 3'd0,
        CmdErrException  = 3'd3,
        CmdErrHaltResume = 3'd4
    } cmderr_e;

    typedef enum logic [1:0] {
        Idle,
        Go,
        Resume,
        CmdExecuting
    } ctrl_state_e;

endpackage
